// ==== glb_ctrl.f ====
glb_ctrl_pkg.sv
stage_if.sv
instr_decoder.sv
pingpong_sync.sv
tile_stage.sv
layer_tracker.sv
mover_cmd_issuer.sv
glb_ctrl.sv
tb_clock_gen.sv
tb_glb_ctrl.sv

// ==== glb_ctrl.sv ====
module glb_ctrl
    import glb_ctrl_pkg::*;
#(
    parameter int BUF_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    output logic                  instr_ready,
    input  logic [INSTR_W-1:0]    instr_data,
    output logic                  act_cmd_valid,
    input  logic                  act_cmd_ready,
    output logic [CMD_W-1:0]      act_cmd_data,
    output logic                  wgt_cmd_valid,
    input  logic                  wgt_cmd_ready,
    output logic [CMD_W-1:0]      wgt_cmd_data,
    output logic                  out_cmd_valid,
    input  logic                  out_cmd_ready,
    output logic [CMD_W-1:0]      out_cmd_data,
    input  logic                  ld_valid,
    input  logic                  ex_valid,
    input  logic                  wb_valid,
    output logic                  ld_buf_en,
    output logic                  ex_buf_en,
    output logic                  wb_buf_en,
    output logic [BUF_ADDR_W-1:0] ld_buf_addr,
    output logic [BUF_ADDR_W-1:0] ex_buf_addr,
    output logic [BUF_ADDR_W-1:0] wb_buf_addr,
    output logic                  ld_sel,
    output logic                  ex_sel,
    output logic                  wb_sel,
    output logic                  wb_status,
    output logic                  tile_done
);

    layer_cfg_t            cfg;
    logic                  layer_start;
    logic                  wb_last_tile;
    logic                  beat_v [NUM_STAGES];
    logic                  buf_en_v [NUM_STAGES];
    logic [BUF_ADDR_W-1:0] buf_addr_v [NUM_STAGES];
    mover_cmd_t            act_cmd;
    mover_cmd_t            wgt_cmd;
    mover_cmd_t            out_cmd;

    stage_if stg_if [NUM_STAGES] ();

    instr_decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_data  (instr_data),
        .cfg         (cfg),
        .layer_start (layer_start),
        .layer_end   (stg_if[WB].eol)
    );

    pingpong_sync u_sync (
        .clk         (clk),
        .rst_n       (rst_n),
        .layer_start (layer_start),
        .stg         (stg_if),
        .ld_sel      (ld_sel),
        .ex_sel      (ex_sel),
        .wb_sel      (wb_sel),
        .wb_status   (wb_status)
    );

    assign beat_v[LD] = ld_valid;
    assign beat_v[EX] = ex_valid;
    assign beat_v[WB] = wb_valid;

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        tile_stage #(
            .BUF_ADDR_W (BUF_ADDR_W)
        ) u_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .stg        (stg_if[g]),
            .beat_limit (cfg.beats[g]),
            .beat       (beat_v[g]),
            .buf_en     (buf_en_v[g]),
            .buf_addr   (buf_addr_v[g])
        );
    end

    assign ld_buf_en   = buf_en_v[LD];
    assign ex_buf_en   = buf_en_v[EX];
    assign wb_buf_en   = buf_en_v[WB];
    assign ld_buf_addr = buf_addr_v[LD];
    assign ex_buf_addr = buf_addr_v[EX];
    assign wb_buf_addr = buf_addr_v[WB];
    assign tile_done   = stg_if[WB].done;

    layer_tracker u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .tile_count   (cfg.tile_count),
        .stg          (stg_if),
        .wb_last_tile (wb_last_tile)
    );

    mover_cmd_issuer u_issuer (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .wb_last_tile  (wb_last_tile),
        .ld_start      (stg_if[LD].start),
        .wb_start      (stg_if[WB].start),
        .act_cmd_valid (act_cmd_valid),
        .act_cmd_ready (act_cmd_ready),
        .act_cmd_data  (act_cmd),
        .wgt_cmd_valid (wgt_cmd_valid),
        .wgt_cmd_ready (wgt_cmd_ready),
        .wgt_cmd_data  (wgt_cmd),
        .out_cmd_valid (out_cmd_valid),
        .out_cmd_ready (out_cmd_ready),
        .out_cmd_data  (out_cmd)
    );

    assign act_cmd_data = act_cmd;
    assign wgt_cmd_data = wgt_cmd;
    assign out_cmd_data = out_cmd;

endmodule

// ==== glb_ctrl_pkg.sv ====
package glb_ctrl_pkg;

    localparam int INSTR_W    = 64;
    localparam int CMD_W      = 80;
    localparam int BEAT_W     = 16;
    localparam int TILE_W     = 16;
    localparam int BTT_W      = 24;
    localparam int EXT_ADDR_W = 32;
    localparam int NUM_STAGES = 3;

    typedef enum logic [1:0] {
        LD = 2'd0,
        EX = 2'd1,
        WB = 2'd2
    } stage_e;

    // opcodes 5..7 are legal but carry nothing
    typedef enum logic [2:0] {
        OP_BEATS = 3'd0,
        OP_TILES = 3'd1,
        OP_ACT   = 3'd2,
        OP_WGT   = 3'd3,
        OP_OUT   = 3'd4
    } opcode_e;

    typedef struct packed {
        logic [BTT_W-1:0]      btt;
        logic [EXT_ADDR_W-1:0] ext_addr;
    } xfer_cfg_t;

    typedef struct packed {
        logic [NUM_STAGES-1:0][BEAT_W-1:0] beats;  // indexed by stage_e
        logic [TILE_W-1:0]                 tile_count;
        logic                              last_layer;
        xfer_cfg_t                         act;
        xfer_cfg_t                         wgt;
        xfer_cfg_t                         out;
    } layer_cfg_t;

    // datamover command word
    typedef struct packed {
        logic [3:0]            rsvd_hi;
        logic [3:0]            tag;
        logic [7:0]            rsvd_mid;
        logic [EXT_ADDR_W-1:0] saddr;
        logic                  drr;
        logic                  eof;
        logic [5:0]            rsvd_lo;
        logic                  cmd_type;  // 1 = incrementing burst
        logic [BTT_W-2:0]      btt;
    } mover_cmd_t;

endpackage

// ==== instr_decoder.sv ====
module instr_decoder
    import glb_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    output logic               instr_ready,
    input  logic [INSTR_W-1:0] instr_data,
    output layer_cfg_t         cfg,
    output logic               layer_start,
    input  logic               layer_end
);

    logic    accept;
    logic    running;
    opcode_e opcode;

    function automatic xfer_cfg_t xfer_field(input logic [INSTR_W-1:0] d);
        xfer_cfg_t x;
        x.btt      = d[BTT_W-1:0];
        x.ext_addr = d[BTT_W +: EXT_ADDR_W];
        return x;
    endfunction

    assign accept      = instr_valid & instr_ready & instr_data[INSTR_W-1];  // marker bit
    assign opcode      = opcode_e'(instr_data[62:60]);
    assign layer_start = accept & (opcode == OP_OUT);
    assign instr_ready = ~running;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (accept) begin
            case (opcode)
                OP_BEATS: begin
                    for (int i = 0; i < NUM_STAGES; i++) begin
                        cfg.beats[i] <= instr_data[i*BEAT_W +: BEAT_W];
                    end
                end
                OP_TILES: begin
                    cfg.tile_count <= instr_data[TILE_W-1:0];
                    cfg.last_layer <= instr_data[16];
                end
                OP_ACT:  cfg.act <= xfer_field(instr_data);
                OP_WGT:  cfg.wgt <= xfer_field(instr_data);
                OP_OUT:  cfg.out <= xfer_field(instr_data);  // also kicks off the layer
                default: ;
            endcase
        end
    end

    // no new instructions while a layer is in flight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else if (layer_end) begin
            running <= 1'b0;
        end else if (layer_start) begin
            running <= 1'b1;
        end
    end

endmodule

// ==== layer_tracker.sv ====
module layer_tracker
    import glb_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [TILE_W-1:0] tile_count,
    stage_if.tracker          stg [NUM_STAGES],
    output logic              wb_last_tile
);

    logic [TILE_W-1:0] tile_cnt [NUM_STAGES];
    logic              last_tile [NUM_STAGES];

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
        assign last_tile[g] = (tile_cnt[g] == tile_count - 1'b1);
        assign stg[g].eol   = stg[g].done & last_tile[g];

        // wraps so the next layer starts from tile 0
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                tile_cnt[g] <= '0;
            end else if (stg[g].done) begin
                tile_cnt[g] <= last_tile[g] ? '0 : tile_cnt[g] + 1'b1;
            end
        end
    end

    assign wb_last_tile = last_tile[WB];

endmodule

// ==== mover_cmd_issuer.sv ====
module mover_cmd_issuer
    import glb_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  layer_cfg_t cfg,
    input  logic       wb_last_tile,
    input  logic       ld_start,
    input  logic       wb_start,
    output logic       act_cmd_valid,
    input  logic       act_cmd_ready,
    output mover_cmd_t act_cmd_data,
    output logic       wgt_cmd_valid,
    input  logic       wgt_cmd_ready,
    output mover_cmd_t wgt_cmd_data,
    output logic       out_cmd_valid,
    input  logic       out_cmd_ready,
    output mover_cmd_t out_cmd_data
);

    logic [2:0] start_v;  // {out, wgt, act}
    logic [2:0] ready_v;
    logic [2:0] valid_r;
    logic [2:0] hs;
    logic [3:0] out_tag;

    function automatic mover_cmd_t fmt_cmd(input xfer_cfg_t x, input logic [3:0] tag);
        mover_cmd_t c;
        c          = '0;
        c.tag      = tag;
        c.saddr    = x.ext_addr;
        c.eof      = 1'b1;
        c.cmd_type = 1'b1;
        c.btt      = x.btt[BTT_W-2:0];
        return c;
    endfunction

    assign out_tag = (cfg.last_layer & wb_last_tile) ? 4'hf : 4'h0;  // end of network

    assign act_cmd_data = fmt_cmd(cfg.act, 4'h0);
    assign wgt_cmd_data = fmt_cmd(cfg.wgt, 4'h0);

    // tag must follow the tile being written back
    always_ff @(posedge clk) begin
        if (wb_start) begin
            out_cmd_data <= fmt_cmd(cfg.out, out_tag);
        end
    end

    assign start_v = {wb_start, ld_start, ld_start};
    assign ready_v = {out_cmd_ready, wgt_cmd_ready, act_cmd_ready};
    assign hs      = valid_r & ready_v;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= '0;
        end else begin
            valid_r <= start_v | (valid_r & ~hs);  // new start wins over accept
        end
    end

    assign {out_cmd_valid, wgt_cmd_valid, act_cmd_valid} = valid_r;

    // tile start from the synchroniser while the previous command is still waiting
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        (start_v & valid_r & ~ready_v) == '0);

endmodule

// ==== pingpong_sync.sv ====
module pingpong_sync
    import glb_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  layer_start,
    stage_if.sync stg [NUM_STAGES],
    output logic  ld_sel,
    output logic  ex_sel,
    output logic  wb_sel,
    output logic  wb_status
);

    // ld waits busy until the layer start, ex and wb idle
    localparam logic [NUM_STAGES-1:0] BUSY_RST = 3'b001;
    localparam logic [NUM_STAGES-1:0] FLAG_RST = 3'b110;

    logic [NUM_STAGES-1:0] busy;
    logic [NUM_STAGES-1:0] flag;
    logic [NUM_STAGES-1:0] fin;   // stage has run all tiles of the layer
    logic [NUM_STAGES-1:0] sync;
    logic [NUM_STAGES-1:0] start;
    logic [NUM_STAGES-1:0] done;
    logic [NUM_STAGES-1:0] eol;
    logic                  layer_end;

    assign done      = {stg[WB].done, stg[EX].done, stg[LD].done};
    assign eol       = {stg[WB].eol, stg[EX].eol, stg[LD].eol};
    assign layer_end = eol[WB];

    always_comb begin
        sync[LD] = ~busy[LD] & ~busy[EX] & (flag[LD] ^ flag[EX]) & ~fin[LD];
        sync[WB] = ~busy[WB] & ~busy[EX] & (flag[WB] ^ flag[EX]);
        // ex may run when one neighbour buffer pair is free
        sync[EX] = ~fin[EX] & ((~busy[LD] & ~busy[EX] & ~busy[WB])
                             | (~busy[LD] & ~busy[EX] & (~flag[WB] ^ flag[EX]))
                             | (~busy[WB] & ~busy[EX] & (~flag[LD] ^ flag[EX])));
        start     = sync;
        start[LD] = sync[LD] | layer_start;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= BUSY_RST;
            flag <= FLAG_RST;
            fin  <= '0;
        end else if (layer_end) begin
            busy <= BUSY_RST;
            flag <= FLAG_RST;
            fin  <= '0;
        end else begin
            busy <= start | (busy & ~done);
            flag <= flag ^ sync;
            fin  <= fin | eol;
        end
    end

    assign stg[LD].start = start[LD];
    assign stg[EX].start = start[EX];
    assign stg[WB].start = start[WB];
    assign stg[LD].busy  = busy[LD];
    assign stg[EX].busy  = busy[EX];
    assign stg[WB].busy  = busy[WB];

    assign ld_sel    = flag[LD];
    assign ex_sel    = flag[EX];
    assign wb_sel    = flag[WB];
    assign wb_status = busy[WB];

    // a stage is never restarted before its sequencer reports done
    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_chk
        a_start_done: assert property (@(posedge clk) disable iff (!rst_n)
            start[g] |=> (!start[g] until_with done[g]));
    end

endmodule

// ==== stage_if.sv ====
interface stage_if;

    logic start;  // one-cycle pulse
    logic done;   // last beat of a tile
    logic eol;    // done that closes the layer
    logic busy;   // synchroniser view of the stage

    modport sync (
        output start,
        output busy,
        input  done,
        input  eol
    );

    modport stage (input start, input busy, output done);

    modport tracker (input done, output eol);

endinterface

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;  // released off the edge like the other inputs
    end

endmodule

// ==== tb_glb_ctrl.sv ====
module tb_glb_ctrl
    import glb_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          BUF_ADDR_W = 4;
    localparam int          TILES      = 4;
    localparam int          LAYERS     = 2;
    localparam int          N_ACCEPT   = 11;  // 5 per layer plus one ignored opcode
    localparam logic [31:0] SEED       = 32'hbe5a_633c;

    logic                             clk;
    logic                             rst_n;
    logic                             instr_valid;
    logic                             instr_ready;
    logic [INSTR_W-1:0]               instr_data;
    logic [2:0]                       cmd_valid;  // index 0 act, 1 wgt, 2 out
    logic [2:0]                       cmd_ready;
    logic [2:0][CMD_W-1:0]            cmd_data;
    logic [2:0]                       beat;       // index by stage_e
    logic [2:0]                       buf_en;
    logic [2:0][BUF_ADDR_W-1:0]       buf_addr;
    logic [2:0]                       sel;
    logic                             wb_status;
    logic                             tile_done;

    logic [31:0] lfsr;
    int          n_err;
    int          n_chk;
    int          n_accept;
    int          n_done;
    int          cycles;
    int          max_cycles;
    int          n_cmd [3];
    int          wait_cnt [3];
    int          exp_idx [3];
    int          n_end [3];    // tiles finished per stage, over all layers
    logic [2:0]  pend;
    mover_cmd_t  pend_data [3];
    logic        in_layer;
    logic        prev_done;

    tb_clock_gen #(.PERIOD(100), .RST_CYCLES(8)) u_clk (.clk(clk), .rst_n(rst_n));

    glb_ctrl #(.BUF_ADDR_W(BUF_ADDR_W)) dut_i (
        .clk (clk), .rst_n (rst_n),
        .instr_valid (instr_valid), .instr_ready (instr_ready), .instr_data (instr_data),
        .act_cmd_valid (cmd_valid[0]), .act_cmd_ready (cmd_ready[0]),
        .act_cmd_data (cmd_data[0]),
        .wgt_cmd_valid (cmd_valid[1]), .wgt_cmd_ready (cmd_ready[1]),
        .wgt_cmd_data (cmd_data[1]),
        .out_cmd_valid (cmd_valid[2]), .out_cmd_ready (cmd_ready[2]),
        .out_cmd_data (cmd_data[2]),
        .ld_valid (beat[0]), .ex_valid (beat[1]), .wb_valid (beat[2]),
        .ld_buf_en (buf_en[0]), .ex_buf_en (buf_en[1]), .wb_buf_en (buf_en[2]),
        .ld_buf_addr (buf_addr[0]), .ex_buf_addr (buf_addr[1]), .wb_buf_addr (buf_addr[2]),
        .ld_sel (sel[0]), .ex_sel (sel[1]), .wb_sel (sel[2]),
        .wb_status (wb_status), .tile_done (tile_done)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    function automatic logic [BEAT_W-1:0] beat_limit(input int layer, input int stage);
        return BEAT_W'(4 + (layer + stage) % 3);
    endfunction

    function automatic int limit_sum();
        int sum;
        int best;
        best = 0;
        for (int l = 0; l < LAYERS; l++) begin
            sum = 0;
            for (int s = 0; s < NUM_STAGES; s++) begin
                sum += beat_limit(l, s);
            end
            best = (sum > best) ? sum : best;
        end
        return best;
    endfunction

    // bit 23 set on purpose since the command keeps only 23 bits
    function automatic logic [BTT_W-1:0] xfer_btt(input int layer, input int stream);
        return 24'h80_0000 | BTT_W'((stream + 1) * 'h1100 + layer * 'h40);
    endfunction

    function automatic logic [EXT_ADDR_W-1:0] xfer_addr(input int layer, input int stream);
        return 32'h1000_0000 * (stream + 1) + 32'h0002_0000 * layer + 32'h40;
    endfunction

    function automatic logic [59:0] xfer_payload(input int layer, input int stream);
        return {4'h0, xfer_addr(layer, stream), xfer_btt(layer, stream)};
    endfunction

    function automatic logic [INSTR_W-1:0] make_instr(input opcode_e op, input logic [59:0] p);
        return {1'b1, op, p};
    endfunction

    function automatic mover_cmd_t ref_cmd(input int layer, input int stream, input int tile);
        mover_cmd_t       c;
        logic [BTT_W-1:0] b;
        c          = '0;
        b          = xfer_btt(layer, stream);
        c.tag      = (stream == 2 && layer == LAYERS - 1 && tile == TILES - 1) ? 4'hf : 4'h0;
        c.saddr    = xfer_addr(layer, stream);
        c.drr      = 1'b0;
        c.eof      = 1'b1;
        c.cmd_type = 1'b1;
        c.btt      = b[BTT_W-2:0];
        return c;
    endfunction

    task automatic check_cmd(input string what, input mover_cmd_t got, input mover_cmd_t exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input logic [BUF_ADDR_W-1:0] got,
                              input logic [BUF_ADDR_W-1:0] exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        n_chk++;
        if (got != exp) begin
            n_err++;
            $display("FAILED %0t: %s counted %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // valid stays high until the caller drops it
    task automatic send_instr(input logic [INSTR_W-1:0] d);
        @(posedge clk);
        #10;
        instr_valid = 1'b1;
        instr_data  = d;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);
        end
    endtask

    task automatic run_layer(input int l);
        send_instr(make_instr(OP_BEATS, {12'h0, beat_limit(l, 2), beat_limit(l, 1),
                                         beat_limit(l, 0)}));
        send_instr(make_instr(OP_TILES, {43'h0, l == LAYERS - 1, 16'(TILES)}));
        if (l == 0) begin
            send_instr({1'b1, 3'd5, 60'hfff});  // unused opcode
        end
        send_instr(make_instr(OP_ACT, xfer_payload(l, 0)));
        if (l == 0) begin
            send_instr({1'b0, OP_ACT, 60'hbad});  // no marker bit
        end
        send_instr(make_instr(OP_WGT, xfer_payload(l, 1)));
        send_instr(make_instr(OP_OUT, xfer_payload(l, 2)));
        @(posedge clk);
        #10;
        instr_data = make_instr(OP_WGT, 60'h0bad_0bad);  // offered while the layer runs
        wait (n_done == TILES * (l + 1));
        @(posedge clk);
        #10;
        instr_valid = 1'b0;
    endtask

    task automatic watch_instr();
        check_bit("instr_ready", instr_ready, !in_layer);
        if (instr_valid && instr_ready && instr_data[INSTR_W-1]) begin
            n_accept++;
            if (instr_data[62:60] == OP_OUT) begin
                in_layer = 1'b1;
            end
        end
    endtask

    task automatic watch_cmds();
        for (int s = 0; s < 3; s++) begin
            if (pend[s]) begin
                check_bit($sformatf("held valid of stream %0d", s), cmd_valid[s], 1'b1);
                check_cmd($sformatf("held data of stream %0d", s), cmd_data[s], pend_data[s]);
            end
            if (cmd_valid[s] && cmd_ready[s]) begin
                check_cmd($sformatf("command of stream %0d", s), cmd_data[s],
                          ref_cmd(n_cmd[s] / TILES, s, n_cmd[s] % TILES));
                n_cmd[s]++;
            end
            pend[s]      = cmd_valid[s] && !cmd_ready[s];
            pend_data[s] = mover_cmd_t'(cmd_data[s]);
        end
    endtask

    task automatic watch_stages();
        logic exp_done;
        int   k;
        int   lim;
        exp_done = 1'b0;
        // downstream first so that an end and a begin in one cycle still count as overlap
        for (int s = NUM_STAGES - 1; s >= 0; s--) begin
            // mid-tile every beat must reach the buffer
            if (buf_en[s] || exp_idx[s] != 0) begin
                check_bit($sformatf("buf_en of stage %0d", s), buf_en[s], beat[s]);
            end
            if (buf_en[s]) begin
                k   = n_end[s] % TILES;
                lim = beat_limit(n_end[s] / TILES, s);
                check_addr($sformatf("buf_addr of stage %0d", s), buf_addr[s],
                           BUF_ADDR_W'(exp_idx[s]));
                check_bit($sformatf("sel of stage %0d", s), sel[s], k[0]);
                if (s == WB) begin
                    check_bit("wb_status during write-back", wb_status, 1'b1);
                end
                if (exp_idx[s] == 0 && s > 0 && n_end[s-1] <= n_end[s]) begin
                    n_err++;
                    $display("%0t: stage %0d began tile %0d before the stage ahead finished it",
                             $time, s, n_end[s]);
                end
                if (exp_idx[s] == lim - 1) begin
                    exp_idx[s] = 0;
                    n_end[s]++;
                    exp_done   = (s == WB);
                end else begin
                    exp_idx[s]++;
                end
            end
        end
        check_bit("tile_done", tile_done, exp_done);
        if (prev_done) begin
            check_bit("wb_status after tile_done", wb_status, 1'b0);
        end
        prev_done = tile_done;
        if (tile_done) begin
            n_done++;
            if (n_done % TILES == 0) begin
                in_layer = 1'b0;
                for (int s = 0; s < 3; s++) begin
                    check_count($sformatf("commands of stream %0d at layer end", s),
                                n_cmd[s], n_done);
                end
            end
        end
    endtask

    // beats and readies 10 ns after the edge
    always @(posedge clk) begin
        logic b;
        #10;
        for (int s = 0; s < 3; s++) begin
            rand_bit(b);
            beat[s]     = b;
            wait_cnt[s] = cmd_valid[s] ? wait_cnt[s] + 1 : 0;
            rand_bit(b);
            cmd_ready[s] = b | (wait_cnt[s] >= 2);  // keeps a command from being overrun
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            watch_instr();
            watch_cmds();
            watch_stages();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr_data  = '0;
        beat        = '0;
        cmd_ready   = '0;
        lfsr        = SEED;
        n_err       = 0;
        n_chk       = 0;
        n_accept    = 0;
        n_done      = 0;
        cycles      = 0;
        pend        = '0;
        in_layer    = 1'b0;
        prev_done   = 1'b0;
        for (int s = 0; s < 3; s++) begin
            n_cmd[s]    = 0;
            wait_cnt[s] = 0;
            exp_idx[s]  = 0;
            n_end[s]    = 0;
        end
        max_cycles = 4 * TILES * limit_sum() * 8 * LAYERS;
        wait (rst_n === 1'b1);
        for (int l = 0; l < LAYERS; l++) begin
            run_layer(l);
        end
        repeat (4) @(negedge clk);
        for (int s = 0; s < 3; s++) begin
            check_count($sformatf("commands of stream %0d", s), n_cmd[s], TILES * LAYERS);
            check_count($sformatf("tiles of stage %0d", s), n_end[s], TILES * LAYERS);
        end
        check_count("tile_done pulses", n_done, TILES * LAYERS);
        check_count("accepted instructions", n_accept, N_ACCEPT);
        $display("checks %0d, errors %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tile_stage.sv ====
module tile_stage
    import glb_ctrl_pkg::*;
#(
    parameter int BUF_ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    stage_if.stage                stg,
    input  logic [BEAT_W-1:0]     beat_limit,
    input  logic                  beat,
    output logic                  buf_en,
    output logic [BUF_ADDR_W-1:0] buf_addr
);

    logic              running;
    logic [BEAT_W-1:0] idx;
    logic              last_beat;

    assign buf_en    = running & beat;
    assign buf_addr  = idx[BUF_ADDR_W-1:0];
    assign last_beat = (idx == beat_limit - 1'b1);
    assign stg.done  = buf_en & last_beat;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (stg.start) begin
            running <= 1'b1;
            idx     <= '0;
        end else if (stg.done) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (buf_en) begin
            idx <= idx + 1'b1;
        end
    end

    a_limit_fits: assert property (@(posedge clk) disable iff (!rst_n)
        stg.start |-> (beat_limit != '0) && (beat_limit <= BEAT_W'(1 << BUF_ADDR_W)));

    // synchroniser must still count this stage as busy
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        stg.done |-> stg.busy);

endmodule
